/* bench/slice_tb.sv */
module slice_tb;

  import slice_cfg_pkg::*;
  import slice_op_pkg::*;

  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned RESET_CYCLES = 8;
  localparam string       TEST_FILE    = "bench/slice_tests.txt";

  logic       clk_i;
  logic       reset_i;
  slice_req_t in_req_i;
  logic       in_valid_i;
  logic       in_ready_o;
  slice_rsp_t out_rsp_o;
  logic       out_valid_o;
  logic       out_ready_i;
  logic       busy_o;

  // Test table and the responses the DUT still owes, oldest first
  slice_req_t req_tab[$];
  slice_rsp_t exp_tab[$];
  slice_rsp_t pend_q[$];

  int unsigned next_idx;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;
  int unsigned value_errs;
  int unsigned ctrl_errs;
  bit          running;
  bit          drained;
  bit          timed_out;

  simd_slice_top UUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_req_i    (in_req_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_rsp_o   (out_rsp_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  // --------------------------------------------------------------------------
  // Test file loading
  // --------------------------------------------------------------------------
  task automatic load_tests();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] op_v, fmt_v, vec_v, mask_v;
    logic [31:0] a_v, b_v, res_v, st_v;
    slice_req_t  req;
    slice_rsp_t  rsp;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      ctrl_errs++;
      $display("Could not open the test file %s", TEST_FILE);
      return;
    end
    while (!$feof(fd)) begin
      line   = "";
      fields = $fgets(line, fd);
      // Comment and blank lines
      if (line.len() < 2 || line.substr(0, 1) == "//") begin
        continue;
      end
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                       op_v, fmt_v, vec_v, mask_v, a_v, b_v, res_v, st_v);
      if (fields != 8) begin
        ctrl_errs++;
        $display("Malformed line in the test file: %s", line);
        continue;
      end
      req.op             = operation_e'(op_v[2:0]);
      req.fmt            = fp_format_e'(fmt_v[0]);
      req.vectorial      = vec_v[0];
      req.mask           = mask_v[NUM_LANES-1:0];
      req.operand_a.fp32 = a_v;
      req.operand_b.fp32 = b_v;
      rsp.result.fp32    = res_v;
      rsp.status         = status_t'(st_v[4:0]);
      req_tab.push_back(req);
      exp_tab.push_back(rsp);
    end
    $fclose(fd);
  endtask

  task automatic check_response();
    slice_rsp_t exp;
    assert (pend_q.size() != 0) else begin
      ctrl_errs++;
      $display("A response came out with no request outstanding at cycle %0d", cycle_cnt);
    end
    if (pend_q.size() != 0) begin
      exp = pend_q.pop_front();
      assert (out_rsp_o.result.fp32 == exp.result.fp32) else begin
        value_errs++;
        $display("** Error out_rsp_o.result: expected %h, got %h",
                 exp.result.fp32, out_rsp_o.result.fp32);
      end
      assert (out_rsp_o.status == exp.status) else begin
        value_errs++;
        $display("** Error out_rsp_o.status: expected %h, got %h", exp.status, out_rsp_o.status);
      end
    end
  endtask

  // Valid holds with the same data until the DUT takes the item
  task automatic drive_inputs(bit accepted);
    if (!in_valid_i || accepted) begin
      if (next_idx < req_tab.size()) begin
        in_valid_i <= ($urandom % 4) != 0;
        in_req_i   <= req_tab[next_idx];
      end else begin
        in_valid_i <= 1'b0;
      end
    end
    out_ready_i <= ($urandom % 3) != 0;
  endtask

  task automatic check_idle();
    assert (!out_valid_o) else begin
      ctrl_errs++;
      $display("** Error out_valid_o: expected %h, got %h", 1'b0, out_valid_o);
    end
    assert (!busy_o) else begin
      ctrl_errs++;
      $display("** Error busy_o: expected %h, got %h", 1'b0, busy_o);
    end
    assert (in_ready_o) else begin
      ctrl_errs++;
      $display("** Error in_ready_o: expected %h, got %h", 1'b1, in_ready_o);
    end
  endtask

  // --------------------------------------------------------------------------
  // Handshakes, busy tracking and run limit
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin : handshake_monitor
    bit accepted;
    if (running && !drained && !timed_out) begin
      cycle_cnt++;
      accepted = in_valid_i && in_ready_o;
      assert (busy_o == (pend_q.size() != 0)) else begin
        ctrl_errs++;
        $display("** Error busy_o: expected %h, got %h", pend_q.size() != 0, busy_o);
      end
      if (out_valid_o && out_ready_i) begin
        check_response();
      end
      if (accepted) begin
        pend_q.push_back(exp_tab[next_idx]);
        next_idx++;
      end
      drive_inputs(accepted);
      if (next_idx == req_tab.size() && pend_q.size() == 0) begin
        drained = 1'b1;
      end else if (cycle_cnt >= cycle_limit) begin
        timed_out = 1'b1;
        $display("Run timed out after %0d cycles with %0d responses outstanding",
                 cycle_cnt, pend_q.size() + req_tab.size() - next_idx);
      end
    end
  end

  initial begin : main
    void'($urandom(28768));
    running     = 1'b0;
    drained     = 1'b0;
    timed_out   = 1'b0;
    next_idx    = 0;
    cycle_cnt   = 0;
    value_errs  = 0;
    ctrl_errs   = 0;
    reset_i     = 1'b1;
    in_req_i    = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    load_tests();
    if (req_tab.size() == 0) begin
      ctrl_errs++;
      $display("No tests were read from %s", TEST_FILE);
    end
    cycle_limit = 8 * req_tab.size() + 100;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_idle();
    running = 1'b1;
    wait (drained || timed_out);
    @(negedge clk_i);
    if (drained) begin
      check_idle();
    end
    $display("Errors: %0d value, %0d control, %0d timeout", value_errs, ctrl_errs, timed_out);
    if (value_errs == 0 && ctrl_errs == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* bench/slice_tests.txt */
// op fmt vectorial mask operand_a operand_b expected_result expected_status (all hex)
// op 0 SGNJ 1 SGNJN 2 SGNJX 3 MIN 4 MAX, fmt 0 FP32 1 FP16, status bit 4 is nv
0 0 0 1 3f800000 c0000000 bf800000 00
1 0 0 1 3f800000 c0000000 3f800000 00
2 0 0 1 bf800000 c0000000 3f800000 00
0 0 0 1 7f800001 80000000 ff800001 00
3 0 0 1 c0000000 bf800000 c0000000 00
4 0 0 1 c0000000 bf800000 bf800000 00
3 0 0 1 00000000 80000000 80000000 00
4 0 0 1 80000000 00000000 00000000 00
3 0 0 1 7fc00000 3f800000 3f800000 00
4 0 0 1 3f800000 7f800001 3f800000 10
4 0 0 2 ff800001 40000000 40000000 00
3 0 0 1 ffc00000 7fc12345 7fc00000 00
3 0 1 3 3f000000 bf000000 bf000000 00
0 1 1 3 3c00bc00 c0004000 bc003c00 00
1 1 1 3 4200c200 00008000 c2004200 00
2 1 1 3 bc003c00 bc00bc00 3c00bc00 00
3 1 1 3 3c00c000 4000bc00 3c00c000 00
4 1 1 3 3c00c000 4000bc00 4000bc00 00
3 1 1 3 7e008000 3c000000 3c008000 00
4 1 1 3 7c013c00 40007e00 40003c00 10
4 1 1 1 7c013c00 40007e00 40003c00 00
3 1 1 2 3c007c01 40004000 3c004000 00
3 1 1 3 00017e00 80017c01 80017e00 10
0 1 0 1 abcd3c00 0000c000 ffffbc00 00
3 1 0 3 7c013c00 7c01bc00 ffffbc00 00
4 1 0 1 ffff7c01 ffff7e00 ffff7e00 10
2 1 0 1 00003555 00008000 ffffb555 00

/* list.f */
logic/slice_cfg_pkg.sv
logic/slice_op_pkg.sv
logic/lane_pipe.sv
logic/lane_unit.sv
logic/slice_dispatch.sv
logic/result_assembly.sv
logic/simd_slice_top.sv
bench/slice_tb.sv

/* logic/lane_pipe.sv */
module lane_pipe (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  slice_op_pkg::lane_rsp_t data_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  output slice_op_pkg::lane_rsp_t data_o,
  output logic                    valid_o,
  input  logic                    ready_i,
  output logic                    busy_o
);

  import slice_cfg_pkg::*;
  import slice_op_pkg::*;

  // Index i holds the item after i register stages
  lane_rsp_t [0:NUM_PIPE_REGS] stage_data;
  logic      [0:NUM_PIPE_REGS] stage_valid;
  logic      [0:NUM_PIPE_REGS] stage_ready;

  assign stage_data[0]  = data_i;
  assign stage_valid[0] = valid_i;
  assign ready_o        = stage_ready[0];

  for (genvar i = 0; i < NUM_PIPE_REGS; i++) begin : gen_stage
    logic load;

    // Advance when the next stage moves on or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] || !stage_valid[i+1];
    assign load           = stage_ready[i] && stage_valid[i];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    // Payload only moves together with a real item
    always_ff @(posedge clk_i) begin
      if (load) begin
        stage_data[i+1] <= stage_data[i];
      end
    end
  end

  // Downstream ready enters at the last stage
  assign stage_ready[NUM_PIPE_REGS] = ready_i;

  assign data_o  = stage_data[NUM_PIPE_REGS];
  assign valid_o = stage_valid[NUM_PIPE_REGS];
  assign busy_o  = |stage_valid[1:NUM_PIPE_REGS];

endmodule

/* logic/lane_unit.sv */
module lane_unit #(
  parameter bit Fp32Enable = 1'b1
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  slice_op_pkg::lane_req_t req_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  output slice_op_pkg::lane_rsp_t rsp_o,
  output logic                    valid_o,
  input  logic                    ready_i,
  output logic                    busy_o
);

  import slice_cfg_pkg::*;
  import slice_op_pkg::*;

  // Operand split into sign and magnitude plus its NaN class
  typedef struct packed {
    logic                  sign;
    logic [FP32_WIDTH-2:0] mag;
    logic                  is_nan;
    logic                  is_snan;
  } operand_info_t;

  logic          is_fp32;
  operand_info_t info_a;
  operand_info_t info_b;
  lane_rsp_t     op_rsp;

  function automatic operand_info_t decode(logic [SLICE_WIDTH-1:0] word, logic fp32);
    operand_info_t info;
    if (fp32) begin
      info.sign   = word[FP32_WIDTH-1];
      info.mag    = word[FP32_WIDTH-2:0];
      info.is_nan = (&word[FP32_WIDTH-2 -: FP32_EXP_BITS]) && (|word[FP32_MAN_BITS-1:0]);
      // Quiet bit is the top mantissa bit
      info.is_snan = info.is_nan && !word[FP32_MAN_BITS-1];
    end else begin
      info.sign    = word[FP16_WIDTH-1];
      info.mag     = (FP32_WIDTH-1)'(word[FP16_WIDTH-2:0]);
      info.is_nan  = (&word[FP16_WIDTH-2 -: FP16_EXP_BITS]) && (|word[FP16_MAN_BITS-1:0]);
      info.is_snan = info.is_nan && !word[FP16_MAN_BITS-1];
    end
    return info;
  endfunction

  // FP16 results come out NaN-boxed
  function automatic logic [SLICE_WIDTH-1:0] encode(logic sign, logic [FP32_WIDTH-2:0] mag,
                                                    logic fp32);
    if (fp32) begin
      return {sign, mag};
    end
    return {{FP16_WIDTH{1'b1}}, sign, mag[FP16_WIDTH-2:0]};
  endfunction

  // A lane without FP32 support runs every item as FP16
  assign is_fp32 = Fp32Enable && (req_i.fmt == FP32);

  assign info_a = decode(req_i.operand_a, is_fp32);
  assign info_b = decode(req_i.operand_b, is_fp32);

  // --------------------------------------------------------------------------
  // Sign injection and min/max
  // --------------------------------------------------------------------------
  always_comb begin : compute
    logic a_less;

    // Sign-magnitude order, -0 below +0
    if (info_a.sign != info_b.sign) begin
      a_less = info_a.sign;
    end else if (info_a.sign) begin
      a_less = info_a.mag > info_b.mag;
    end else begin
      a_less = info_a.mag < info_b.mag;
    end

    op_rsp.result = encode(info_a.sign, info_a.mag, is_fp32);
    op_rsp.status = '0;
    op_rsp.mask   = req_i.mask;
    op_rsp.aux    = req_i.aux;

    case (req_i.op)
      SGNJ:  op_rsp.result = encode(info_b.sign, info_a.mag, is_fp32);
      SGNJN: op_rsp.result = encode(!info_b.sign, info_a.mag, is_fp32);
      SGNJX: op_rsp.result = encode(info_a.sign ^ info_b.sign, info_a.mag, is_fp32);
      MIN, MAX: begin
        op_rsp.status.nv = info_a.is_snan || info_b.is_snan;
        if (info_a.is_nan && info_b.is_nan) begin
          op_rsp.result = is_fp32 ? FP32_QNAN : {{FP16_WIDTH{1'b1}}, FP16_QNAN};
        end else if (info_a.is_nan) begin
          op_rsp.result = encode(info_b.sign, info_b.mag, is_fp32);
        end else if (info_b.is_nan) begin
          op_rsp.result = encode(info_a.sign, info_a.mag, is_fp32);
        end else if (a_less == (req_i.op == MIN)) begin
          op_rsp.result = encode(info_a.sign, info_a.mag, is_fp32);
        end else begin
          op_rsp.result = encode(info_b.sign, info_b.mag, is_fp32);
        end
      end
      default: ;
    endcase
  end

  lane_pipe u_lane_pipe (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (op_rsp),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_o  (rsp_o),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .busy_o  (busy_o)
  );

endmodule

/* logic/result_assembly.sv */
module result_assembly (
  input  slice_op_pkg::lane_rsp_t [slice_cfg_pkg::NUM_LANES-1:0] lane_rsp_i,
  input  logic [slice_cfg_pkg::NUM_LANES-1:0]                    lane_valid_i,
  output logic [slice_cfg_pkg::NUM_LANES-1:0]                    lane_ready_o,
  input  logic [slice_cfg_pkg::NUM_LANES-1:0]                    lane_busy_i,
  output slice_op_pkg::slice_rsp_t                               out_rsp_o,
  output logic                                                   out_valid_o,
  input  logic                                                   out_ready_i,
  output logic                                                   busy_o
);

  import slice_cfg_pkg::*;
  import slice_op_pkg::*;

  lane_aux_t            res_aux;
  logic [NUM_LANES-1:0] lane_active;
  slice_word_u          res_word;

  // Lane 0 carries the aux data of the item at the head
  assign res_aux = lane_rsp_i[0].aux;

  // Upper lane only takes part in vector results
  always_comb begin : handshake
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      lane_ready_o[lane] = out_ready_i && ((lane == 0) || res_aux.vectorial);
      lane_active[lane]  = lane_valid_i[lane] && ((lane == 0) || res_aux.vectorial);
    end
  end

  // --------------------------------------------------------------------------
  // Result packing
  // --------------------------------------------------------------------------
  always_comb begin : pack_result
    if (res_aux.fmt == FP32) begin
      res_word.fp32 = lane_rsp_i[0].result;
    end else begin
      res_word.fp16[0] = lane_rsp_i[0].result[FP16_WIDTH-1:0];
      // Scalar FP16 gets NaN-boxed
      res_word.fp16[1] = res_aux.vectorial ? lane_rsp_i[1].result[FP16_WIDTH-1:0] : '1;
    end
  end

  // Masked-off lanes do not flag anything
  always_comb begin : collapse_status
    status_t status;
    status = '0;
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      if (lane_active[lane]) begin
        status = status | (lane_rsp_i[lane].status & {$bits(status_t){lane_rsp_i[lane].mask}});
      end
    end
    out_rsp_o.status = status;
  end

  assign out_rsp_o.result = res_word;
  assign out_valid_o      = lane_valid_i[0];
  assign busy_o           = |lane_busy_i;

endmodule

/* logic/simd_slice_top.sv */
module simd_slice_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  slice_op_pkg::slice_req_t in_req_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  output slice_op_pkg::slice_rsp_t out_rsp_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic                     busy_o
);

  import slice_cfg_pkg::*;
  import slice_op_pkg::*;

  // Dispatch to lanes
  lane_req_t [NUM_LANES-1:0] lane_req;
  logic      [NUM_LANES-1:0] lane_in_valid;
  logic      [NUM_LANES-1:0] lane_in_ready;

  // Lanes to assembly
  lane_rsp_t [NUM_LANES-1:0] lane_rsp;
  logic      [NUM_LANES-1:0] lane_out_valid;
  logic      [NUM_LANES-1:0] lane_out_ready;
  logic      [NUM_LANES-1:0] lane_busy;

  slice_dispatch u_dispatch (
    .in_req_i     (in_req_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .lane_req_o   (lane_req),
    .lane_valid_o (lane_in_valid),
    .lane_ready_i (lane_in_ready)
  );

  // Only lane 0 carries the FP32 datapath
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lane
    lane_unit #(
      .Fp32Enable (lane == 0)
    ) u_lane (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (lane_req[lane]),
      .valid_i (lane_in_valid[lane]),
      .ready_o (lane_in_ready[lane]),
      .rsp_o   (lane_rsp[lane]),
      .valid_o (lane_out_valid[lane]),
      .ready_i (lane_out_ready[lane]),
      .busy_o  (lane_busy[lane])
    );
  end

  result_assembly u_assembly (
    .lane_rsp_i   (lane_rsp),
    .lane_valid_i (lane_out_valid),
    .lane_ready_o (lane_out_ready),
    .lane_busy_i  (lane_busy),
    .out_rsp_o    (out_rsp_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .busy_o       (busy_o)
  );

endmodule

/* logic/slice_cfg_pkg.sv */
package slice_cfg_pkg;

  // --------------------------------------------------------------------------
  // Slice geometry
  // --------------------------------------------------------------------------

  // One slice word holds one FP32 value or two FP16 values
  localparam int unsigned SLICE_WIDTH = 32;
  localparam int unsigned NUM_LANES   = 2;

  localparam int unsigned FP32_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;

  // Exponent and mantissa sizes, used for NaN classification
  localparam int unsigned FP32_EXP_BITS = 8;
  localparam int unsigned FP32_MAN_BITS = 23;
  localparam int unsigned FP16_EXP_BITS = 5;
  localparam int unsigned FP16_MAN_BITS = 10;

  // --------------------------------------------------------------------------
  // Timing and special values
  // --------------------------------------------------------------------------

  // Register stages in every lane
  localparam int unsigned NUM_PIPE_REGS = 2;

  // Canonical quiet NaNs
  localparam logic [FP16_WIDTH-1:0] FP16_QNAN = 16'h7e00;
  localparam logic [FP32_WIDTH-1:0] FP32_QNAN = 32'h7fc0_0000;

endpackage

/* logic/slice_dispatch.sv */
module slice_dispatch (
  input  slice_op_pkg::slice_req_t                           in_req_i,
  input  logic                                               in_valid_i,
  output logic                                               in_ready_o,
  output slice_op_pkg::lane_req_t [slice_cfg_pkg::NUM_LANES-1:0] lane_req_o,
  output logic [slice_cfg_pkg::NUM_LANES-1:0]                lane_valid_o,
  input  logic [slice_cfg_pkg::NUM_LANES-1:0]                lane_ready_i
);

  import slice_cfg_pkg::*;
  import slice_op_pkg::*;

  logic      vec_op;
  lane_aux_t aux_data;

  // Only FP16 items can be split over the lanes
  assign vec_op = in_req_i.vectorial && (in_req_i.fmt == FP16);

  assign aux_data.fmt       = in_req_i.fmt;
  assign aux_data.vectorial = vec_op;

  // Lane 0 sees every item, so its ready speaks for the slice
  assign in_ready_o = lane_ready_i[0];

  // --------------------------------------------------------------------------
  // Per-lane operand slicing
  // --------------------------------------------------------------------------
  always_comb begin : slice_operands
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      lane_req_o[lane].op   = in_req_i.op;
      lane_req_o[lane].fmt  = in_req_i.fmt;
      lane_req_o[lane].mask = in_req_i.mask[lane];
      lane_req_o[lane].aux  = aux_data;

      if ((in_req_i.fmt == FP32) && (lane == 0)) begin
        lane_req_o[lane].operand_a = in_req_i.operand_a.fp32;
        lane_req_o[lane].operand_b = in_req_i.operand_b.fp32;
      end else begin
        // Each lane takes its own half, upper bits boxed
        lane_req_o[lane].operand_a = {{FP16_WIDTH{1'b1}}, in_req_i.operand_a.fp16[lane]};
        lane_req_o[lane].operand_b = {{FP16_WIDTH{1'b1}}, in_req_i.operand_b.fp16[lane]};
      end

      // Upper lane only works on vector items
      lane_valid_o[lane] = in_valid_i && ((lane == 0) || vec_op);
    end
  end

endmodule

/* logic/slice_op_pkg.sv */
package slice_op_pkg;

  import slice_cfg_pkg::*;

  // Non-computational operations
  typedef enum logic [2:0] {
    SGNJ,
    SGNJN,
    SGNJX,
    MIN,
    MAX
  } operation_e;

  typedef enum logic {
    FP32,
    FP16
  } fp_format_e;

  // IEEE exception flags, only nv is raised by this slice
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // Slice word seen as one FP32 value or as two FP16 halves
  typedef union packed {
    logic [FP32_WIDTH-1:0]                fp32;
    logic [NUM_LANES-1:0][FP16_WIDTH-1:0] fp16;
  } slice_word_u;

  typedef struct packed {
    operation_e  op;
    fp_format_e  fmt;
    logic        vectorial;
    logic [NUM_LANES-1:0] mask;
    slice_word_u operand_a;
    slice_word_u operand_b;
  } slice_req_t;

  // Travels with every item through the lanes
  typedef struct packed {
    fp_format_e fmt;
    logic       vectorial;
  } lane_aux_t;

  typedef struct packed {
    operation_e             op;
    fp_format_e             fmt;
    logic [SLICE_WIDTH-1:0] operand_a;
    logic [SLICE_WIDTH-1:0] operand_b;
    logic                   mask;
    lane_aux_t              aux;
  } lane_req_t;

  typedef struct packed {
    logic [SLICE_WIDTH-1:0] result;
    status_t                status;
    logic                   mask;
    lane_aux_t              aux;
  } lane_rsp_t;

  typedef struct packed {
    slice_word_u result;
    status_t     status;
  } slice_rsp_t;

endpackage

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log &&
  verilator --binary --timing --assert -Wno-fatal --top-module slice_tb -f list.f \
    -o slice_sim > build.log 2>&1 &&
  ./obj_dir/slice_sim > sim.log 2>&1 ||
  { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
